// File: avmm_burst_mapper.sv
// ==============================
// AFU bursts must be legal Avalon bursts of 1 to 64 beats. A long read
// stalls the AFU until its last chunk has been handed downstream
// ==============================

`timescale 1ns/100ps
`default_nettype none

module avmm_burst_mapper
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  afu_cmd_t afu_cmd,
    output logic     afu_waitrequest,
    output mem_cmd_t mem_cmd,
    input  logic     mem_waitrequest
);

    // ==============================
    // Burst tracking state
    // ==============================

    // Beats of the current AFU burst not yet handled. For a write this
    // counts data beats still to come, for a read the beats not yet requested
    logic [AFU_BURST_WIDTH-1:0] beats_left;

    // Address where the next memory chunk starts
    logic [ADDR_WIDTH-1:0]      next_addr;

    // Write beats still owed to the chunk already opened downstream
    logic [MEM_BURST_WIDTH-1:0] chunk_left;

    logic                       in_burst;
    logic [AFU_BURST_WIDTH-1:0] total;
    logic [ADDR_WIDTH-1:0]      base;
    logic [MEM_BURST_WIDTH-1:0] chunk_len;
    logic                       chunk_start;
    logic                       is_read;
    logic                       read_more;
    logic                       accept;

    // ==============================
    // Chunk selection
    // ==============================

    // With nothing in flight the AFU command itself starts a new burst
    assign in_burst = (beats_left != '0);
    assign total    = in_burst ? beats_left : afu_cmd.burstcount;
    assign base     = in_burst ? next_addr : afu_cmd.address;

    // Chunk size is the smaller of the remaining beats and the memory limit
    assign chunk_len = (total > AFU_BURST_WIDTH'(MEM_MAX_BURST)) ?
                       MEM_BURST_WIDTH'(MEM_MAX_BURST) :
                       total[MEM_BURST_WIDTH-1:0];

    // A write beat opens a new chunk when the previous chunk is complete
    assign chunk_start = (chunk_left == '0);
    assign is_read     = (afu_cmd.op == MEM_OP_READ);

    // The AFU read is only taken once its final chunk goes downstream
    assign read_more = is_read && (total > AFU_BURST_WIDTH'(MEM_MAX_BURST));
    assign accept    = (afu_cmd.op != MEM_OP_IDLE) && !mem_waitrequest;

    assign afu_waitrequest = mem_waitrequest || read_more;

    // The chunk goes out in the same cycle, no register on this path
    always_comb
    begin
        mem_cmd.op         = afu_cmd.op;
        mem_cmd.address    = base;
        mem_cmd.burstcount = chunk_len;
        mem_cmd.writedata  = afu_cmd.writedata;
        mem_cmd.byteenable = afu_cmd.byteenable;
    end

    // ==============================
    // Counter updates
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_left <= '0;
            chunk_left <= '0;
        end
        else if (accept)
        begin
            if (is_read)
            begin
                // Drops to zero once the last chunk has been requested
                beats_left <= total - AFU_BURST_WIDTH'(chunk_len);
            end
            else if (chunk_start)
            begin
                // First beat of a chunk carries address and burst count
                beats_left <= total - AFU_BURST_WIDTH'(1);
                chunk_left <= chunk_len - MEM_BURST_WIDTH'(1);
            end
            else
            begin
                // Middle beats are data only
                beats_left <= beats_left - AFU_BURST_WIDTH'(1);
                chunk_left <= chunk_left - MEM_BURST_WIDTH'(1);
            end
        end
    end

    // The next chunk address moves on whenever a chunk is opened
    always_ff @(posedge clk)
    begin
        if (accept && (is_read || chunk_start))
        begin
            next_addr <= base + ADDR_WIDTH'(chunk_len);
        end
    end

endmodule

`default_nettype wire

// File: avmm_reg_stage.sv
// ==============================
// Adds one cycle each way. Waitrequest upstream is registered, so the
// skid register absorbs the one command that arrives as it rises
// ==============================

`timescale 1ns/100ps
`default_nettype none

module avmm_reg_stage
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  mem_cmd_t up_cmd,
    output logic     up_waitrequest,
    output mem_cmd_t down_cmd,
    input  logic     down_waitrequest,
    input  mem_rsp_t down_rsp,
    output mem_rsp_t up_rsp
);

    // Main register drives downstream, skid catches one overflow command
    mem_cmd_t main_q;
    mem_cmd_t skid_q;

    logic skid_full;
    logic main_free;
    logic up_accept;

    // ==============================
    // Command path
    // ==============================

    // An idle op marks either register as empty
    assign skid_full = (skid_q.op != MEM_OP_IDLE);

    // Driven straight from a flop, so no path runs through the stage
    assign up_waitrequest = skid_full;

    // Main may load when empty or when downstream takes its command
    assign main_free = (main_q.op == MEM_OP_IDLE) || !down_waitrequest;
    assign up_accept = (up_cmd.op != MEM_OP_IDLE) && !skid_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            main_q.op <= MEM_OP_IDLE;
            skid_q.op <= MEM_OP_IDLE;
        end
        else if (main_free)
        begin
            if (skid_full)
            begin
                // Skid drains first to keep command order
                main_q    <= skid_q;
                skid_q.op <= MEM_OP_IDLE;
            end
            else if (up_accept)
            begin
                main_q <= up_cmd;
            end
            else
            begin
                main_q.op <= MEM_OP_IDLE;
            end
        end
        else if (up_accept)
        begin
            // Downstream stalled while upstream still saw us ready
            skid_q <= up_cmd;
        end
    end

    assign down_cmd = main_q;

    // ==============================
    // Response path
    // ==============================

    // Responses carry no back-pressure, a plain register is enough
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            up_rsp.readdatavalid <= 1'b0;
        end
        else
        begin
            up_rsp <= down_rsp;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
mem_pkg.sv
avmm_burst_mapper.sv
avmm_reg_stage.sv
local_mem_bank.sv
local_mem_as_avmm.sv
tb_local_mem_assertions.sv
tb_local_mem.sv

// File: local_mem_as_avmm.sv
// ==============================
// Single clock domain. Read latency grows with back-pressure, so the
// last readdatavalid beat of a burst is what marks its end
// ==============================

`timescale 1ns/100ps
`default_nettype none

module local_mem_as_avmm
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  afu_cmd_t afu_cmd,
    output logic     afu_waitrequest,
    output mem_rsp_t afu_rsp
);

    // ==============================
    // Chain wiring
    // ==============================

    // Index 0 faces the mapper, index NUM_REG_STAGES faces the bank
    mem_cmd_t stage_cmd         [NUM_REG_STAGES+1];
    logic     stage_waitrequest [NUM_REG_STAGES+1];
    mem_rsp_t stage_rsp         [NUM_REG_STAGES+1];

    // Splits AFU bursts into chunks of at most MEM_MAX_BURST beats
    avmm_burst_mapper i_mapper
    (
        .clk             (clk),
        .reset           (reset),
        .afu_cmd         (afu_cmd),
        .afu_waitrequest (afu_waitrequest),
        .mem_cmd         (stage_cmd[0]),
        .mem_waitrequest (stage_waitrequest[0])
    );

    // Identical timing stages, each one honoring waitrequest
    generate
        for (genvar k = 0; k < NUM_REG_STAGES; k++)
        begin : g_stage
            avmm_reg_stage i_stage
            (
                .clk              (clk),
                .reset            (reset),
                .up_cmd           (stage_cmd[k]),
                .up_waitrequest   (stage_waitrequest[k]),
                .down_cmd         (stage_cmd[k+1]),
                .down_waitrequest (stage_waitrequest[k+1]),
                .down_rsp         (stage_rsp[k+1]),
                .up_rsp           (stage_rsp[k])
            );
        end
    endgenerate

    // The bank drains the far end of the chain
    local_mem_bank i_bank
    (
        .clk         (clk),
        .reset       (reset),
        .cmd         (stage_cmd[NUM_REG_STAGES]),
        .waitrequest (stage_waitrequest[NUM_REG_STAGES]),
        .rsp         (stage_rsp[NUM_REG_STAGES])
    );

    assign afu_rsp = stage_rsp[0];

endmodule

`default_nettype wire

// File: local_mem_bank.sv
// ==============================
// Behavioral model. Reset leaves the array alone, and a read holds
// waitrequest high for as many cycles as it has beats
// ==============================

`timescale 1ns/100ps
`default_nettype none

module local_mem_bank
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  mem_cmd_t cmd,
    output logic     waitrequest,
    output mem_rsp_t rsp
);

    typedef enum logic {
        BANK_IDLE,
        BANK_READ
    } bank_state_t;

    bank_state_t state;

    logic [DATA_WIDTH-1:0] mem_array [MEM_DEPTH_WORDS];

    // Write burst tracking, wr_left counts beats owed after the current one
    logic [ADDR_WIDTH-1:0]      wr_addr;
    logic [MEM_BURST_WIDTH-1:0] wr_left;
    logic [ADDR_WIDTH-1:0]      wr_target;

    // Read burst streaming
    logic [ADDR_WIDTH-1:0]      rd_addr;
    logic [MEM_BURST_WIDTH-1:0] rd_left;

    logic wr_accept;
    logic rd_accept;

    // Latency shift register, the last entry drives the response
    mem_rsp_t lat_pipe [MEM_READ_LATENCY];

    // ==============================
    // Handshake
    // ==============================

    assign waitrequest = (state == BANK_READ);
    assign wr_accept   = (cmd.op == MEM_OP_WRITE) && !waitrequest;
    assign rd_accept   = (cmd.op == MEM_OP_READ) && !waitrequest;

    // Only the first beat of a write burst carries a valid address
    assign wr_target = (wr_left == '0) ? cmd.address : wr_addr;

    // ==============================
    // Write side
    // ==============================

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            // Only the low index bits are kept, so addresses wrap
            for (int b = 0; b < BYTE_EN_WIDTH; b++)
            begin
                if (cmd.byteenable[b])
                begin
                    mem_array[wr_target[MEM_INDEX_WIDTH-1:0]][b*8 +: 8] <=
                        cmd.writedata[b*8 +: 8];
                end
            end
            wr_addr <= wr_target + ADDR_WIDTH'(1);
        end
    end

    // ==============================
    // Control FSM
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= BANK_IDLE;
            wr_left <= '0;
            rd_left <= '0;
        end
        else
        begin
            if (wr_accept)
            begin
                wr_left <= (wr_left == '0) ? cmd.burstcount - MEM_BURST_WIDTH'(1) :
                                             wr_left - MEM_BURST_WIDTH'(1);
            end

            case (state)
                BANK_IDLE:
                begin
                    if (rd_accept)
                    begin
                        state   <= BANK_READ;
                        rd_left <= cmd.burstcount;
                    end
                end
                BANK_READ:
                begin
                    // One beat enters the latency pipe every cycle
                    rd_left <= rd_left - MEM_BURST_WIDTH'(1);
                    if (rd_left == MEM_BURST_WIDTH'(1))
                    begin
                        state <= BANK_IDLE;
                    end
                end
                default:
                begin
                    state <= BANK_IDLE;
                end
            endcase
        end
    end

    // Read address steps through the burst
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            rd_addr <= cmd.address;
        end
        else if (state == BANK_READ)
        begin
            rd_addr <= rd_addr + ADDR_WIDTH'(1);
        end
    end

    // ==============================
    // Read latency pipe
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int k = 0; k < MEM_READ_LATENCY; k++)
            begin
                lat_pipe[k].readdatavalid <= 1'b0;
            end
        end
        else
        begin
            lat_pipe[0].readdatavalid <= (state == BANK_READ);
            lat_pipe[0].readdata      <= mem_array[rd_addr[MEM_INDEX_WIDTH-1:0]];
            for (int k = 1; k < MEM_READ_LATENCY; k++)
            begin
                lat_pipe[k] <= lat_pipe[k-1];
            end
        end
    end

    assign rsp = lat_pipe[MEM_READ_LATENCY-1];

endmodule

`default_nettype wire

// File: mem_pkg.sv
// ==============================
// Built for one configuration only. A memory-side burst is 1 to 4 beats,
// an AFU burst 1 to 64, and bank addresses wrap modulo MEM_DEPTH_WORDS
// ==============================

`default_nettype none

package mem_pkg;

    // ==============================
    // Widths and limits
    // ==============================

    // Word address, one word per DATA_WIDTH bits
    localparam int ADDR_WIDTH      = 16;
    localparam int DATA_WIDTH      = 64;
    localparam int BYTE_EN_WIDTH   = DATA_WIDTH / 8;

    // AFU burst counts run from 1 to 64, so 7 bits are needed
    localparam int AFU_BURST_WIDTH = 7;

    // Memory side burst counts run from 1 to 4
    localparam int MEM_BURST_WIDTH = 3;
    localparam int MEM_MAX_BURST   = 4;

    // Waitrequest-honoring stages between the mapper and the bank
    localparam int NUM_REG_STAGES  = 2;

    // Bank size and the index width used to wrap addresses into it
    localparam int MEM_DEPTH_WORDS  = 1024;
    localparam int MEM_INDEX_WIDTH  = $clog2(MEM_DEPTH_WORDS);

    // Cycles from a bank read accept to the first returned beat
    localparam int MEM_READ_LATENCY = 2;

    // ==============================
    // Command and response types
    // ==============================

    // Idle means no command is offered on the bus this cycle
    typedef enum logic [1:0] {
        MEM_OP_IDLE  = 2'd0,
        MEM_OP_READ  = 2'd1,
        MEM_OP_WRITE = 2'd2
    } mem_op_t;

    // Command as the AFU presents it, with the wide burst count
    typedef struct packed {
        mem_op_t                    op;
        logic [ADDR_WIDTH-1:0]      address;
        logic [AFU_BURST_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [BYTE_EN_WIDTH-1:0]   byteenable;
    } afu_cmd_t;

    // Command on the memory side of the mapper
    typedef struct packed {
        mem_op_t                    op;
        logic [ADDR_WIDTH-1:0]      address;
        logic [MEM_BURST_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [BYTE_EN_WIDTH-1:0]   byteenable;
    } mem_cmd_t;

    // Read response beat, never back-pressured
    typedef struct packed {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the log.
# A simulator that stops on an assertion error counts as a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_local_mem -f flist.f -o tb_local_mem_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_local_mem_sim > "$LOG" 2>&1 \
    || echo "TEST FAILED: simulator exited with an error" >> "$LOG"
grep -q "TEST PASSED" "$LOG" || echo "TEST FAILED: no pass message in the log" >> "$LOG"
cat "$LOG"

grep -q "TEST FAILED" "$LOG" && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// File: tb_local_mem.sv
// ==============================
// Directed tests only. The bank is never cleared, so a test reads back
// only words that some earlier write has set
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_local_mem
    import mem_pkg::*;
();

    localparam int          CLK_PERIOD      = 40;
    localparam logic [31:0] LFSR_SEED       = 32'h7d8dfe3d;
    // Beats moved by each test in turn: single, long bursts, byte enables,
    // back-to-back traffic and reset in idle
    localparam int          TOTAL_BEATS     = 2 + (13 + 64) * 2 + 9 + 30 + 4 + 13;
    localparam int          CYCLES_PER_BEAT = 20;
    localparam int          WATCHDOG_CYCLES = TOTAL_BEATS * CYCLES_PER_BEAT + 200;

    logic     clk = 1'b0;
    logic     reset;
    afu_cmd_t afu_cmd;
    logic     afu_waitrequest;
    mem_rsp_t afu_rsp;

    // Expected contents of the bank, with the same wrap and byte rules
    logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH_WORDS];
    logic [DATA_WIDTH-1:0] exp_q [$];
    logic [DATA_WIDTH-1:0] rsp_q [$];
    logic [31:0]           lfsr_state;
    int                    error_count;
    int                    check_count;
    int                    test_count;

    local_mem_as_avmm i_dut
    (
        .clk             (clk),
        .reset           (reset),
        .afu_cmd         (afu_cmd),
        .afu_waitrequest (afu_waitrequest),
        .afu_rsp         (afu_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Responses have no back-pressure, so every valid beat is captured here
    always @(negedge clk)
    begin
        if (afu_rsp.readdatavalid === 1'b1)
        begin
            rsp_q.push_back(afu_rsp.readdata);
        end
    end

    // ==============================
    // Helpers
    // ==============================

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit drawn
    function automatic logic [63:0] random_bits(input int width);
        logic [63:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < width; i++)
        begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[62:0], feedback};
        end
        return value;
    endfunction

    // The bank keeps only the low address bits
    function automatic int word_index(input int address);
        return address % MEM_DEPTH_WORDS;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after the accept
    task automatic send_beat(input afu_cmd_t beat);
        logic stalled;
        stalled = 1'b1;
        afu_cmd = beat;
        while (stalled)
        begin
            // Waitrequest settles on the new command and then holds until the edge
            #1;
            stalled = afu_waitrequest;
            @(negedge clk);
        end
    endtask

    task automatic do_write_burst(input logic [ADDR_WIDTH-1:0] address, input int beats,
                                  input logic [BYTE_EN_WIDTH-1:0] mask);
        afu_cmd_t beat;
        int       idx;
        beat            = '0;
        beat.op         = MEM_OP_WRITE;
        beat.address    = address;
        beat.burstcount = AFU_BURST_WIDTH'(beats);
        beat.byteenable = mask;
        for (int i = 0; i < beats; i++)
        begin
            beat.writedata = random_bits(DATA_WIDTH);
            idx = word_index(int'(address) + i);
            for (int b = 0; b < BYTE_EN_WIDTH; b++)
            begin
                if (mask[b])
                begin
                    ref_mem[idx][b*8 +: 8] = beat.writedata[b*8 +: 8];
                end
            end
            send_beat(beat);
        end
        afu_cmd.op = MEM_OP_IDLE;
    endtask

    // Queues the expected beats and hands the read over, without waiting for data
    task automatic issue_read(input logic [ADDR_WIDTH-1:0] address, input int beats);
        afu_cmd_t cmd;
        for (int i = 0; i < beats; i++)
        begin
            exp_q.push_back(ref_mem[word_index(int'(address) + i)]);
        end
        cmd            = '0;
        cmd.op         = MEM_OP_READ;
        cmd.address    = address;
        cmd.burstcount = AFU_BURST_WIDTH'(beats);
        send_beat(cmd);
        afu_cmd.op = MEM_OP_IDLE;
    endtask

    // Waits for every queued beat, then compares them in command order
    task automatic collect_responses(input string label);
        int expected_beats;
        int waited;
        expected_beats = exp_q.size();
        waited = 0;
        while ((rsp_q.size() < expected_beats) &&
               (waited < expected_beats * CYCLES_PER_BEAT + 50))
        begin
            @(negedge clk);
            waited++;
        end
        if (rsp_q.size() < expected_beats)
        begin
            $display("%s: only %0d of %0d read beats arrived in time", label,
                     rsp_q.size(), expected_beats);
            error_count++;
        end
        check_value("afu_rsp beat count", 64'(rsp_q.size()), 64'(expected_beats));
        while ((exp_q.size() > 0) && (rsp_q.size() > 0))
        begin
            check_value("afu_rsp.readdata", rsp_q.pop_front(), exp_q.pop_front());
        end
        exp_q.delete();
        rsp_q.delete();
    endtask

    task automatic do_read_burst(input logic [ADDR_WIDTH-1:0] address, input int beats);
        issue_read(address, beats);
        collect_responses("read burst");
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("%-14s finished with %0d errors", name, error_count - errors_before);
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic test_single_beat();
        logic [ADDR_WIDTH-1:0] address;
        int                    errors_before;
        errors_before = error_count;
        address = ADDR_WIDTH'(random_bits(MEM_INDEX_WIDTH));
        do_write_burst(address, 1, '1);
        do_read_burst(address, 1);
        finish_test("single_beat", errors_before);
    endtask

    task automatic test_long_bursts();
        int errors_before;
        errors_before = error_count;
        do_write_burst(16'd100, 13, '1);
        // Runs from word 1000 past the end of the bank and on to word 39
        do_write_burst(16'd1000, 64, '1);
        do_read_burst(16'd100, 13);
        do_read_burst(16'd1000, 64);
        finish_test("long_bursts", errors_before);
    endtask

    task automatic test_byte_enables();
        logic [BYTE_EN_WIDTH-1:0] mask;
        int                       errors_before;
        errors_before = error_count;
        do_write_burst(16'd300, 1, '1);
        for (int k = 0; k < 4; k++)
        begin
            mask = BYTE_EN_WIDTH'(random_bits(BYTE_EN_WIDTH));
            do_write_burst(16'd300, 1, mask);
            do_read_burst(16'd300, 1);
        end
        finish_test("byte_enables", errors_before);
    endtask

    // Reads keep the bank busy, so the writes behind them meet back-pressure
    task automatic test_back_to_back();
        int errors_before;
        errors_before = error_count;
        issue_read(16'd100, 5);
        do_write_burst(16'd500, 3, '1);
        issue_read(16'd1020, 9);
        do_write_burst(16'd520, 2, '1);
        issue_read(16'd104, 1);
        issue_read(16'd20, 4);
        do_write_burst(16'd540, 4, '1);
        issue_read(16'd1010, 2);
        collect_responses("back_to_back");
        finish_test("back_to_back", errors_before);
    endtask

    task automatic test_reset_idle();
        int errors_before;
        errors_before = error_count;
        // A read is still inside the bank when reset hits, and none of its
        // beats may come back afterwards
        issue_read(16'd100, 4);
        exp_q.delete();
        repeat (2) @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < 10; k++)
        begin
            @(negedge clk);
            check_value("afu_rsp.readdatavalid", 64'(afu_rsp.readdatavalid), 64'd0);
        end
        check_value("afu_waitrequest", 64'(afu_waitrequest), 64'd0);
        rsp_q.delete();
        // Words from the long burst test survive the reset
        do_read_burst(16'd100, 13);
        finish_test("reset_idle", errors_before);
    endtask

    // ==============================
    // Run control
    // ==============================

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t, the tests did not complete in time", $time);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        lfsr_state  = LFSR_SEED;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        reset       = 1'b1;
        afu_cmd     = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        test_single_beat();
        test_long_bursts();
        test_byte_enables();
        test_back_to_back();
        test_reset_idle();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_local_mem_assertions.sv
// ==============================
// Bound to the top level. A read counts as requested in the first
// cycle it is offered, which bounds the beats that may come back
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_local_mem_assertions
    import mem_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input afu_cmd_t afu_cmd,
    input logic     afu_waitrequest,
    input mem_rsp_t afu_rsp
);

    logic [31:0] beats_requested;
    logic [31:0] beats_returned;
    logic        read_held;

    // A long read stays stalled while its early chunks already return data
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_requested <= '0;
            beats_returned  <= '0;
            read_held       <= 1'b0;
        end
        else
        begin
            if ((afu_cmd.op == MEM_OP_READ) && !read_held)
            begin
                beats_requested <= beats_requested + 32'(afu_cmd.burstcount);
            end
            if (afu_rsp.readdatavalid)
            begin
                beats_returned <= beats_returned + 32'd1;
            end
            read_held <= (afu_cmd.op == MEM_OP_READ) && afu_waitrequest;
        end
    end

    // A stalled command stays put until it is taken
    assert property (@(posedge clk) disable iff (reset)
        ((afu_cmd.op != MEM_OP_IDLE) && afu_waitrequest) |=> $stable(afu_cmd))
        else $error("afu_cmd changed while afu_waitrequest was high");

    assert property (@(posedge clk) reset |=> !afu_rsp.readdatavalid)
        else $error("afu_rsp.readdatavalid high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset) beats_returned <= beats_requested)
        else $error("more read beats returned than were requested");

endmodule

bind local_mem_as_avmm tb_local_mem_assertions i_assertions
(
    .clk             (clk),
    .reset           (reset),
    .afu_cmd         (afu_cmd),
    .afu_waitrequest (afu_waitrequest),
    .afu_rsp         (afu_rsp)
);

`default_nettype wire
